/* include/sys_defs.svh */
`ifndef SYS_DEFS_SVH
`define SYS_DEFS_SVH

`define TRUE  1'b1
`define FALSE 1'b0

`endif

/* hw/ooo_pkg.sv */
package ooo_pkg;

    parameter int ROB_DEPTH_DEF = 8;
    parameter int RS_DEPTH_DEF  = 4;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        BEQ = 3'd4,
        LD  = 3'd5,
        ST  = 3'd6
    } op_t;

    typedef logic [31:0] data_t;
    typedef logic [$clog2(ROB_DEPTH_DEF)-1:0] tag_t;

    // ALU path. imm is the branch target for BEQ.
    typedef struct packed {
        op_t   op;
        tag_t  tag;
        data_t src_a;
        data_t src_b;
        data_t imm;
    } alu_entry_t;

    typedef struct packed {
        op_t   op;
        tag_t  tag;
        data_t base;
        data_t offset;
        data_t st_data;
    } mem_entry_t;

endpackage

/* hw/hazard_detection_unit.sv */
`timescale 1ns/1ps
`include "sys_defs.svh"

module hazard_detection_unit (
    input  logic clock,
    input  logic reset,
    input  logic rs_ld_st_full,
    input  logic rs_alu_full,
    input  logic rob_full,
    input  logic lb_full,
    input  logic is_ld_st_inst,
    input  logic is_valid_inst,
    input  logic commit_wr_mem,
    input  logic lb_read_mem,
    input  logic dmem_wait,
    input  logic is_branch,
    input  logic alu_branch,
    input  logic ex_take_branch,
    input  logic alu_wr_valid,
    input  logic alu_wr_written,
    input  logic lb_wr_valid,
    input  logic lb_wr_written,
    input  logic acu_wr_valid,
    input  logic acu_wr_written,
    input  logic acu_wr_mem,
    input  logic acu_rd_mem,
    output logic if_mem_hazard,
    output logic if_enable,
    output logic if_is_enable,
    output logic if_is_flush,
    output logic rob_enable,
    output logic rs_ld_st_enable,
    output logic rs_ld_exec_stall,
    output logic rs_alu_enable,
    output logic rs_alu_exec_stall,
    output logic lb_exec_stall,
    output logic alu_wr_enable,
    output logic lb_wr_enable,
    output logic acu_wr_enable
);

    logic is_stall;
    logic is_enable;
    logic branch_in_exec;

    // ========================================================================
    // Issue stage
    // ========================================================================
    assign is_stall = rob_full
        | (is_ld_st_inst & rs_ld_st_full)
        | (~is_ld_st_inst & rs_alu_full)
        | branch_in_exec;

    assign is_enable = ~is_stall & is_valid_inst & ~ex_take_branch;

    assign rob_enable      = is_enable;
    assign rs_ld_st_enable = is_enable & is_ld_st_inst;
    assign rs_alu_enable   = is_enable & ~is_ld_st_inst;

    assign if_mem_hazard = commit_wr_mem | (lb_read_mem & ~dmem_wait);
    assign if_enable     = ~(if_mem_hazard | is_stall);
    assign if_is_enable  = ~is_stall;
    assign if_is_flush   = ex_take_branch | (if_mem_hazard & ~is_stall);

    // ========================================================================
    // Writeback registers and execution stalls
    // ========================================================================
    assign alu_wr_enable = ~alu_wr_valid | alu_wr_written;
    assign lb_wr_enable  = ~lb_wr_valid | lb_wr_written;
    assign acu_wr_enable = ~acu_wr_valid | acu_wr_written;

    // Store waits on commit, load waits on a free load buffer.
    assign rs_ld_exec_stall = (acu_wr_mem & ~acu_wr_enable) | (acu_rd_mem & lb_full);
    assign rs_alu_exec_stall = ~alu_wr_enable;
    assign lb_exec_stall = commit_wr_mem | ~lb_wr_enable;  // Stores own the port.

    always_ff @(posedge clock) begin
        if (reset) begin
            branch_in_exec <= `FALSE;
        end else if (is_branch && rs_alu_enable) begin
            branch_in_exec <= `TRUE;
        end else if (alu_branch && !rs_alu_exec_stall) begin
            branch_in_exec <= `FALSE;  // Only once per branch.
        end
    end

endmodule

/* hw/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station #(
    parameter type entry_t  = ooo_pkg::alu_entry_t,
    parameter int  RS_DEPTH = ooo_pkg::RS_DEPTH_DEF
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   flush,
    input  logic   enable,
    input  entry_t entry_in,
    input  logic   exec_stall,
    output logic   full,
    output logic   head_valid,
    output entry_t head_entry
);

    localparam int PTR_W = $clog2(RS_DEPTH);
    localparam int CNT_W = $clog2(RS_DEPTH + 1);

    entry_t           entries [RS_DEPTH];
    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(RS_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full       = (count == CNT_W'(RS_DEPTH));
    assign head_valid = (count != '0);
    assign head_entry = entries[head_ptr];

    assign push = enable & ~full;
    assign pop  = head_valid & ~exec_stall;

    always_ff @(posedge clock) begin
        if (push) begin
            entries[tail_ptr] <= entry_in;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                tail_ptr <= next_ptr(tail_ptr);
            end
            if (pop) begin
                head_ptr <= next_ptr(head_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

/* hw/reorder_buffer.sv */
`timescale 1ns/1ps
`include "sys_defs.svh"

module reorder_buffer #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           enable,
    input  logic           is_store,
    output ooo_pkg::tag_t  alloc_tag,
    output logic           full,
    output logic           commit_valid,
    output ooo_pkg::tag_t  commit_tag,
    output ooo_pkg::data_t commit_value,
    output logic           commit_wr_mem,
    input  logic           alu_wr_valid,
    input  ooo_pkg::tag_t  alu_wr_tag,
    input  ooo_pkg::data_t alu_wr_value,
    output logic           alu_wr_written,
    input  logic           lb_wr_valid,
    input  ooo_pkg::tag_t  lb_wr_tag,
    input  ooo_pkg::data_t lb_wr_value,
    output logic           lb_wr_written,
    input  logic           store_done,
    input  ooo_pkg::tag_t  store_tag
);
    import ooo_pkg::*;

    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    logic             done  [ROB_DEPTH];
    logic             store [ROB_DEPTH];
    data_t            value [ROB_DEPTH];
    tag_t             head_ptr;
    tag_t             tail_ptr;
    logic [CNT_W-1:0] count;
    logic             alloc;
    logic             retire;
    logic             head_busy;

    function automatic tag_t next_tag(input tag_t ptr);
        return (ptr == tag_t'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(ROB_DEPTH));
    assign head_busy = (count != '0);
    assign alloc     = enable & ~full;
    assign alloc_tag = tail_ptr;

    // One result per path per cycle, always taken.
    assign alu_wr_written = alu_wr_valid;
    assign lb_wr_written  = lb_wr_valid;

    // ========================================================================
    // In-order commit
    // ========================================================================
    assign commit_valid  = head_busy & done[head_ptr];
    assign commit_tag    = head_ptr;
    assign commit_value  = value[head_ptr];
    assign commit_wr_mem = head_busy & store[head_ptr] & ~done[head_ptr];
    assign retire        = commit_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                done[i] <= `FALSE;
            end
        end else begin
            if (alloc) begin
                done[tail_ptr] <= `FALSE;
                tail_ptr       <= next_tag(tail_ptr);
            end
            if (alu_wr_valid) begin
                done[alu_wr_tag] <= `TRUE;
            end
            if (lb_wr_valid) begin
                done[lb_wr_tag] <= `TRUE;
            end
            if (store_done) begin
                done[store_tag] <= `TRUE;  // Commits next cycle.
            end
            if (retire) begin
                head_ptr <= next_tag(head_ptr);
            end
            count <= count + CNT_W'(alloc) - CNT_W'(retire);
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            store[tail_ptr] <= is_store;
        end
        if (alu_wr_valid) begin
            value[alu_wr_tag] <= alu_wr_value;
        end
        if (lb_wr_valid) begin
            value[lb_wr_tag] <= lb_wr_value;
        end
        if (store_done) begin
            value[store_tag] <= '0;
        end
    end

endmodule

/* hw/alu_exec.sv */
`timescale 1ns/1ps
`include "sys_defs.svh"

module alu_exec (
    input  logic                clock,
    input  logic                reset,
    input  logic                head_valid,
    input  ooo_pkg::alu_entry_t head_entry,
    input  logic                stall,
    input  logic                wr_enable,
    output logic                alu_branch,
    output logic                ex_take_branch,
    output ooo_pkg::data_t      redirect_target,
    output logic                wr_valid,
    output ooo_pkg::tag_t       wr_tag,
    output ooo_pkg::data_t      wr_value
);
    import ooo_pkg::*;

    logic  exec;
    data_t result;

    assign exec            = head_valid & ~stall;
    assign alu_branch      = head_valid & (head_entry.op == BEQ);
    assign ex_take_branch  = alu_branch & ~stall & (head_entry.src_a == head_entry.src_b);
    assign redirect_target = head_entry.imm;

    always_comb begin
        case (head_entry.op)
            ADD:     result = head_entry.src_a + head_entry.src_b;
            SUB:     result = head_entry.src_a - head_entry.src_b;
            AND:     result = head_entry.src_a & head_entry.src_b;
            OR:      result = head_entry.src_a | head_entry.src_b;
            default: result = '0;  // BEQ completes with zero.
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_valid <= `FALSE;
        end else if (wr_enable) begin
            wr_valid <= exec;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_enable && exec) begin
            wr_tag   <= head_entry.tag;
            wr_value <= result;
        end
    end

endmodule

/* hw/mem_unit.sv */
`timescale 1ns/1ps
`include "sys_defs.svh"

module mem_unit (
    input  logic                clock,
    input  logic                reset,
    input  logic                head_valid,
    input  ooo_pkg::mem_entry_t head_entry,
    input  logic                exec_stall,
    input  logic                lb_stall,
    input  logic                acu_wr_enable,
    input  logic                lb_wr_enable,
    input  logic                commit_wr_mem,
    input  ooo_pkg::data_t      dmem_rdata,
    input  logic                dmem_wait,
    output logic                acu_wr_valid,
    output logic                acu_wr_written,
    output logic                acu_wr_mem,
    output logic                acu_rd_mem,
    output logic                lb_full,
    output logic                lb_read_mem,
    output logic                store_done,
    output ooo_pkg::tag_t       store_tag,
    output logic                lb_wr_valid,
    output ooo_pkg::tag_t       lb_wr_tag,
    output ooo_pkg::data_t      lb_wr_value,
    output logic                dmem_req,
    output logic                dmem_we,
    output ooo_pkg::data_t      dmem_addr,
    output ooo_pkg::data_t      dmem_wdata
);
    import ooo_pkg::*;

    logic  take;
    logic  acu_valid;
    logic  acu_store;
    tag_t  acu_tag;
    data_t acu_addr;
    data_t acu_data;
    logic  lb_valid;
    logic  lb_take;
    logic  lb_done;
    tag_t  lb_tag;
    data_t lb_addr;
    logic  store_write;

    // ========================================================================
    // Address calculation, load buffer and store path
    // ========================================================================
    assign take           = head_valid & ~exec_stall;
    assign acu_wr_valid   = acu_valid;
    assign acu_wr_mem     = acu_valid & acu_store;
    assign acu_rd_mem     = acu_valid & ~acu_store;
    assign acu_wr_written = store_done | lb_take;

    assign lb_read_mem = lb_valid & ~lb_stall;
    assign lb_done     = lb_read_mem & ~dmem_wait;
    assign lb_full     = lb_valid & ~lb_done;  // Frees in the cycle the read ends.
    assign lb_take     = acu_rd_mem & ~lb_full;

    assign store_write = acu_wr_mem & commit_wr_mem;
    assign store_done  = store_write & ~dmem_wait;
    assign store_tag   = acu_tag;

    assign dmem_req   = store_write | lb_read_mem;
    assign dmem_we    = store_write;
    assign dmem_addr  = store_write ? acu_addr : lb_addr;
    assign dmem_wdata = acu_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            acu_valid   <= `FALSE;
            lb_valid    <= `FALSE;
            lb_wr_valid <= `FALSE;
        end else begin
            if (acu_wr_enable) begin
                acu_valid <= take;
            end
            if (lb_take) begin
                lb_valid <= `TRUE;
            end else if (lb_done) begin
                lb_valid <= `FALSE;
            end
            if (lb_wr_enable) begin
                lb_wr_valid <= lb_done;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (acu_wr_enable && take) begin
            acu_store <= (head_entry.op == ST);
            acu_tag   <= head_entry.tag;
            acu_addr  <= head_entry.base + head_entry.offset;
            acu_data  <= head_entry.st_data;
        end
        if (lb_take) begin
            lb_tag  <= acu_tag;
            lb_addr <= acu_addr;
        end
        if (lb_wr_enable && lb_done) begin
            lb_wr_tag   <= lb_tag;
            lb_wr_value <= dmem_rdata;
        end
    end

endmodule

/* hw/ooo_core.sv */
`timescale 1ns/1ps
`include "sys_defs.svh"

module ooo_core #(
    parameter int ROB_DEPTH = ooo_pkg::ROB_DEPTH_DEF,
    parameter int RS_DEPTH  = ooo_pkg::RS_DEPTH_DEF
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           inst_valid,
    input  ooo_pkg::op_t   inst_op,
    input  ooo_pkg::data_t inst_a,
    input  ooo_pkg::data_t inst_b,
    input  ooo_pkg::data_t inst_imm,
    input  ooo_pkg::data_t dmem_rdata,
    input  logic           dmem_wait,
    output logic           inst_accept,
    output logic           fetch_enable,
    output logic           decode_flush,
    output logic           branch_redirect,
    output ooo_pkg::data_t redirect_target,
    output logic           commit_valid,
    output ooo_pkg::tag_t  commit_tag,
    output ooo_pkg::data_t commit_value,
    output logic           dmem_req,
    output logic           dmem_we,
    output ooo_pkg::data_t dmem_addr,
    output ooo_pkg::data_t dmem_wdata
);
    import ooo_pkg::*;

    logic rs_ld_st_full, rs_alu_full, rob_full, lb_full;
    logic is_ld_st_inst, is_branch, commit_wr_mem, lb_read_mem;
    logic alu_branch, ex_take_branch;
    logic alu_wr_valid, alu_wr_written, lb_wr_valid, lb_wr_written;
    logic acu_wr_valid, acu_wr_written, acu_wr_mem, acu_rd_mem;
    logic rob_enable, rs_ld_st_enable, rs_alu_enable;
    logic rs_ld_exec_stall, rs_alu_exec_stall, lb_exec_stall;
    logic alu_wr_enable, lb_wr_enable, acu_wr_enable;
    logic store_done;
    tag_t store_tag, alloc_tag, alu_wr_tag, lb_wr_tag;
    data_t alu_wr_value, lb_wr_value;
    logic alu_head_valid, mem_head_valid;
    alu_entry_t alu_in, alu_head;
    mem_entry_t mem_in, mem_head;

    // ========================================================================
    // Decode and dispatch
    // ========================================================================
    assign is_ld_st_inst = (inst_op == LD) | (inst_op == ST);
    assign is_branch     = (inst_op == BEQ);
    assign inst_accept   = rob_enable;
    assign branch_redirect = ex_take_branch;

    assign alu_in = '{op: inst_op, tag: alloc_tag, src_a: inst_a, src_b: inst_b,
                      imm: inst_imm};
    assign mem_in = '{op: inst_op, tag: alloc_tag, base: inst_a, offset: inst_imm,
                      st_data: inst_b};

    hazard_detection_unit hazard (
        .*,
        .is_valid_inst(inst_valid),
        .if_mem_hazard(),
        .if_enable(fetch_enable),
        .if_is_enable(),
        .if_is_flush(decode_flush)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) rob (
        .*,
        .enable(rob_enable),
        .is_store(inst_op == ST),
        .full(rob_full)
    );

    // Nothing younger than a branch sits in the ALU station when it resolves.
    reservation_station #(.entry_t(alu_entry_t), .RS_DEPTH(RS_DEPTH)) rs_alu (
        .clock(clock),
        .reset(reset),
        .flush(ex_take_branch),
        .enable(rs_alu_enable),
        .entry_in(alu_in),
        .exec_stall(rs_alu_exec_stall),
        .full(rs_alu_full),
        .head_valid(alu_head_valid),
        .head_entry(alu_head)
    );

    reservation_station #(.entry_t(mem_entry_t), .RS_DEPTH(RS_DEPTH)) rs_ld_st (
        .clock(clock),
        .reset(reset),
        .flush(`FALSE),
        .enable(rs_ld_st_enable),
        .entry_in(mem_in),
        .exec_stall(rs_ld_exec_stall),
        .full(rs_ld_st_full),
        .head_valid(mem_head_valid),
        .head_entry(mem_head)
    );

    // ========================================================================
    // Execution
    // ========================================================================
    alu_exec alu (
        .clock(clock),
        .reset(reset),
        .head_valid(alu_head_valid),
        .head_entry(alu_head),
        .stall(rs_alu_exec_stall),
        .wr_enable(alu_wr_enable),
        .alu_branch(alu_branch),
        .ex_take_branch(ex_take_branch),
        .redirect_target(redirect_target),
        .wr_valid(alu_wr_valid),
        .wr_tag(alu_wr_tag),
        .wr_value(alu_wr_value)
    );

    mem_unit mem (
        .*,
        .head_valid(mem_head_valid),
        .head_entry(mem_head),
        .exec_stall(rs_ld_exec_stall),
        .lb_stall(lb_exec_stall)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

/* testbench/tb_ooo_core.sv */
`timescale 1ns/1ps

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int ROB_DEPTH     = 8;
    localparam int RS_DEPTH      = 4;
    localparam int RESET_TIMEOUT = 40;
    localparam int ISSUE_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 400;

    typedef struct packed {
        op_t   op;
        data_t value;
        data_t addr;
        data_t data;
        logic  taken;
    } expect_t;

    logic  clock, reset;
    logic  inst_valid, dmem_wait;
    op_t   inst_op;
    data_t inst_a, inst_b, inst_imm, dmem_rdata;
    logic  inst_accept, fetch_enable, decode_flush, branch_redirect;
    logic  commit_valid, dmem_req, dmem_we;
    tag_t  commit_tag;
    data_t redirect_target, commit_value, dmem_addr, dmem_wdata;

    expect_t     pending_q[$];
    data_t       ref_mem [16];
    data_t       mem_model [16];
    logic [31:0] stim_seed = 32'hd245_82e1;
    logic [31:0] mem_seed = ~32'hd245_82e1;
    logic        long_waits = 1'b0;
    logic        taken_live = 1'b0;
    logic        store_written = 1'b0;
    logic        mem_busy = 1'b0;
    data_t       live_target;
    int          wait_left;
    int commits = 0, redirects = 0, taken_commits = 0, drops = 0;
    int stores = 0, loads = 0, max_occupancy = 0;

    tb_clock_gen clock_gen (.clock(clock), .reset(reset));

    ooo_core #(.ROB_DEPTH(ROB_DEPTH), .RS_DEPTH(RS_DEPTH)) uut (
        .clock(clock), .reset(reset),
        .inst_valid(inst_valid), .inst_op(inst_op), .inst_a(inst_a), .inst_b(inst_b),
        .inst_imm(inst_imm), .dmem_rdata(dmem_rdata), .dmem_wait(dmem_wait),
        .inst_accept(inst_accept), .fetch_enable(fetch_enable),
        .decode_flush(decode_flush), .branch_redirect(branch_redirect),
        .redirect_target(redirect_target), .commit_valid(commit_valid),
        .commit_tag(commit_tag), .commit_value(commit_value), .dmem_req(dmem_req),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
    );

    // ========================================================================
    // Helpers
    // ========================================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] draw_stimulus();
        stim_seed = lcg_next(stim_seed);
        return stim_seed;
    endfunction

    function automatic data_t fill_word(input int addr);
        return 32'ha5a5_0000 ^ (addr * 32'h0001_0203);
    endfunction

    function automatic data_t expected_result(input op_t op, input data_t a, input data_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            default: return '0;  // Branches and stores complete with zero.
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input data_t got, input data_t want);
        assert (got === want)
            else report_error($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h",
                                        name, got, want));
    endtask

    task automatic check_idle_outputs();
        check_value("commit_valid", commit_valid, 32'd0);
        check_value("dmem_req", dmem_req, 32'd0);
        check_value("branch_redirect", branch_redirect, 32'd0);
        check_value("inst_accept", inst_accept, 32'd0);
    endtask

    // Holds the instruction until it is accepted or flushed.
    task automatic present_inst(input op_t op, input data_t a, input data_t b, input data_t imm);
        int waited;
        inst_valid <= 1'b1;
        inst_op    <= op;
        inst_a     <= a;
        inst_b     <= b;
        inst_imm   <= imm;
        waited = 0;
        @(posedge clock);
        while (!inst_accept && !decode_flush) begin
            if (waited == ISSUE_TIMEOUT) begin
                report_error("instruction was neither accepted nor flushed in time");
            end
            waited++;
            @(posedge clock);
        end
        if (!inst_accept) begin
            drops++;
        end
    endtask

    task automatic issue_random(input bit with_mem);
        logic [31:0] r, x, y, z;
        r = draw_stimulus();
        x = draw_stimulus();
        y = draw_stimulus();
        z = draw_stimulus();
        if (!with_mem || r[31:28] < 4'd6) begin
            present_inst(op_t'({1'b0, r[27:26]}), x, y, z);
        end else if (r[31:28] < 4'd12) begin
            present_inst(r[23] ? LD : ST, {29'd0, x[31:29]}, y, {29'd0, z[31:29]});
        end else begin
            present_inst(BEQ, x, (r[25:24] != 2'd0) ? x : x + 1, z);  // Mostly taken.
        end
    endtask

    // ========================================================================
    // Data memory model
    // ========================================================================
    initial begin
        for (int k = 0; k < 16; k++) begin
            mem_model[k] = fill_word(k);
            ref_mem[k]   = fill_word(k);
        end
        dmem_wait  = 1'b1;
        dmem_rdata = '0;
    end

    always @(posedge clock) begin : memory_model
        if (reset) begin
            dmem_wait <= 1'b1;
            mem_busy = 1'b0;
        end else if (dmem_req && !dmem_wait) begin
            if (dmem_we) begin
                mem_model[dmem_addr[3:0]] = dmem_wdata;
            end
            mem_busy = 1'b0;
            dmem_wait <= 1'b1;
        end else if (dmem_req) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                mem_seed = lcg_next(mem_seed);
                wait_left = long_waits ? 24 : int'(mem_seed[31:30]);
            end
            if (wait_left == 0) begin
                dmem_wait  <= 1'b0;
                dmem_rdata <= mem_model[dmem_addr[3:0]];
            end else begin
                wait_left--;
            end
        end
    end

    // ========================================================================
    // Reference model and checks
    // ========================================================================
    always @(posedge clock) begin : scoreboard
        int      occupancy;
        expect_t head;
        expect_t entry;
        if (!reset) begin
            occupancy = pending_q.size();
            if (occupancy > max_occupancy) begin
                max_occupancy = occupancy;
            end
            assert (!inst_accept || occupancy < ROB_DEPTH)
                else report_error("inst_accept rose with the ROB full");

            if (branch_redirect) begin
                assert (taken_live)
                    else report_error("branch_redirect with no taken branch in execution");
                check_value("redirect_target", redirect_target, live_target);
                check_value("inst_accept", inst_accept, 32'd0);
                check_value("fetch_enable", fetch_enable, 32'd0);
                check_value("decode_flush", decode_flush, 32'd1);
                taken_live = 1'b0;
                redirects++;
            end else if (taken_live) begin
                check_value("inst_accept", inst_accept, 32'd0);  // Branch still executing.
                check_value("fetch_enable", fetch_enable, 32'd0);
            end

            // No issue stall while fetch runs.
            if (fetch_enable && inst_valid) begin
                check_value("inst_accept", inst_accept, 32'd1);
            end

            if (store_written) begin
                assert (commit_valid === 1'b1)
                    else report_error("store did not commit in the cycle after its write");
            end

            if (commit_valid) begin
                assert (occupancy > 0) else report_error("commit with nothing outstanding");
                head = pending_q.pop_front();
                check_value("commit_tag", commit_tag, commits % ROB_DEPTH);
                check_value("commit_value", commit_value, head.value);
                if (head.op == ST) begin
                    assert (store_written) else report_error("store committed before its write");
                    store_written = 1'b0;
                    stores++;
                end
                if (head.op == LD) begin
                    loads++;
                end
                if (head.op == BEQ && head.taken) begin
                    assert (redirects > taken_commits)
                        else report_error("taken branch committed without a redirect");
                    taken_commits++;
                end
                commits++;
            end

            if (dmem_req && dmem_we && !dmem_wait) begin
                assert (pending_q.size() > 0 && pending_q[0].op == ST)
                    else report_error("memory write while the oldest entry is not a store");
                check_value("dmem_addr", dmem_addr, pending_q[0].addr);
                check_value("dmem_wdata", dmem_wdata, pending_q[0].data);
                store_written = 1'b1;
            end

            if (inst_accept) begin
                entry.op    = inst_op;
                entry.addr  = inst_a + inst_imm;
                entry.data  = inst_b;
                entry.taken = (inst_op == BEQ) && (inst_a == inst_b);
                entry.value = expected_result(inst_op, inst_a, inst_b);
                if (inst_op == LD) begin
                    entry.value = ref_mem[entry.addr[3:0]];
                end else if (inst_op == ST) begin
                    ref_mem[entry.addr[3:0]] = inst_b;  // Program order.
                end
                if (entry.taken) begin
                    taken_live  = 1'b1;
                    live_target = inst_imm;
                end
                pending_q.push_back(entry);
            end
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin : stimulus
        int waited;
        inst_valid = 1'b0;
        inst_op    = ADD;
        inst_a     = '0;
        inst_b     = '0;
        inst_imm   = '0;

        waited = 0;
        repeat (2) @(posedge clock);
        while (reset) begin
            check_idle_outputs();
            if (waited == RESET_TIMEOUT) begin
                report_error("reset was never released");
            end
            waited++;
            @(posedge clock);
        end
        check_idle_outputs();

        repeat (40) issue_random(1'b0);

        // One slow load with ALU work behind it fills the ROB.
        long_waits <= 1'b1;
        present_inst(LD, {29'd0, stim_seed[31:29]}, '0, 32'd5);
        repeat (12) issue_random(1'b0);
        long_waits <= 1'b0;

        repeat (150) issue_random(1'b1);

        inst_valid <= 1'b0;
        waited = 0;
        @(negedge clock);
        while (pending_q.size() != 0) begin
            if (waited == DRAIN_TIMEOUT) begin
                report_error("accepted instructions did not all commit");
            end
            waited++;
            @(negedge clock);
        end
        repeat (8) @(negedge clock);

        if (max_occupancy != ROB_DEPTH || redirects == 0 || drops == 0 ||
            stores == 0 || loads == 0) begin
            report_error("stimulus did not reach every check");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+include
hw/ooo_pkg.sv
hw/hazard_detection_unit.sv
hw/reservation_station.sv
hw/reorder_buffer.sv
hw/alu_exec.sv
hw/mem_unit.sv
hw/ooo_core.sv
testbench/tb_clock_gen.sv
testbench/tb_ooo_core.sv
